/* design/sdram_ahb_pkg.sv */
package sdram_ahb_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////
  localparam int HADDR_SIZE    = 32;
  localparam int HDATA_SIZE    = 32;
  localparam int HDATA_BYTES   = HDATA_SIZE / 8;
  // One SDRAM data word
  localparam int DQ_SIZE       = 16;

  //////////////////////////////////////////////////
  // Write buffer geometry
  //////////////////////////////////////////////////
  // Four AHB words, eight SDRAM words per line
  localparam int WB_LINE_SIZE  = 128;
  localparam int WB_LINE_BYTES = WB_LINE_SIZE / 8;
  localparam int WB_IDX_BITS   = 2;
  localparam int WB_OFFS_BITS  = 4;
  localparam int WB_TAG_SIZE   = HADDR_SIZE - WB_OFFS_BITS;

  // Read side and idle timer
  localparam int RDFIFO_DEPTH  = 8;
  localparam int TIMER_SIZE    = 16;
  localparam int TIMEOUT_SIZE  = 4;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // Only sizes up to the bus width
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010
  } hsize_t;

  typedef enum logic {WR_IDLE, WR_WAIT} wr_state_t;
  typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_DATA} rd_state_t;

endpackage

/* design/ahb_addr_phase.sv */
`timescale 1ns/1ps

module ahb_addr_phase (
  input  logic                                  HCLK,
  input  logic                                  HRESETn,
  input  logic                                  HSEL_i,
  input  sdram_ahb_pkg::htrans_t                HTRANS_i,
  input  sdram_ahb_pkg::hsize_t                 HSIZE_i,
  input  logic                                  HWRITE_i,
  input  logic [sdram_ahb_pkg::HADDR_SIZE -1:0] HADDR_i,
  input  logic                                  HREADY_i,
  output logic                                  addr_write_o,
  output logic                                  addr_read_o,
  output logic [sdram_ahb_pkg::WB_TAG_SIZE-1:0] addr_tag_o,
  output logic [sdram_ahb_pkg::HADDR_SIZE -1:0] addr_rdadr_o,
  output logic                                  beat_write_o,
  output logic [sdram_ahb_pkg::HDATA_BYTES-1:0] beat_be_o,
  output logic [sdram_ahb_pkg::WB_IDX_BITS-1:0] beat_idx_o,
  output logic [sdram_ahb_pkg::WB_TAG_SIZE-1:0] beat_tag_o
);
  import sdram_ahb_pkg::*;

  logic                   xfer;
  logic [HDATA_BYTES-1:0] size_mask;

  // IDLE and BUSY carry no transfer
  assign xfer         = HSEL_i & (HTRANS_i != IDLE) & (HTRANS_i != BUSY);
  assign addr_write_o = xfer &  HWRITE_i;
  assign addr_read_o  = xfer & ~HWRITE_i;
  assign addr_tag_o   = HADDR_i[HADDR_SIZE-1 -: WB_TAG_SIZE];
  // Word aligned, SDRAM returns the full word
  assign addr_rdadr_o = {HADDR_i[HADDR_SIZE-1:$clog2(HDATA_BYTES)], {$clog2(HDATA_BYTES){1'b0}}};

  // Lanes covered by the transfer size
  always_comb
  begin
    case (HSIZE_i)
      BYTE   : size_mask = {{(HDATA_BYTES-1){1'b0}}, 1'b1};
      HWORD  : size_mask = {{(HDATA_BYTES-2){1'b0}}, 2'b11};
      default: size_mask = {HDATA_BYTES{1'b1}};
    endcase
  end

  //////////////////////////////////////////////////
  // Data phase beat
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
      beat_write_o <= 1'b0;
    else if (HREADY_i)
      beat_write_o <= addr_write_o;

  // Byte enables, line index and tag
  always_ff @(posedge HCLK)
    if (HREADY_i)
    begin
      beat_be_o  <= size_mask << HADDR_i[$clog2(HDATA_BYTES)-1:0];
      beat_idx_o <= HADDR_i[WB_OFFS_BITS-1 -: WB_IDX_BITS];
      beat_tag_o <= addr_tag_o;
    end

endmodule

/* design/write_buffer.sv */
`timescale 1ns/1ps

module write_buffer (
  input  logic                                    HCLK,
  input  logic                                    HRESETn,
  input  logic [sdram_ahb_pkg::HDATA_SIZE   -1:0] HWDATA_i,
  input  logic [sdram_ahb_pkg::HDATA_BYTES  -1:0] beat_be_i,
  input  logic [sdram_ahb_pkg::WB_IDX_BITS  -1:0] beat_idx_i,
  input  logic [sdram_ahb_pkg::WB_TAG_SIZE  -1:0] beat_tag_i,
  input  logic                                    wb_we_i,
  input  logic                                    pingpong_toggle_i,
  input  logic                                    wr_accept_i,
  output logic                                    active_o,
  output logic [sdram_ahb_pkg::WB_TAG_SIZE  -1:0] tag0_o,
  output logic [sdram_ahb_pkg::WB_TAG_SIZE  -1:0] tag1_o,
  output logic                                    dirty0_o,
  output logic                                    dirty1_o,
  output logic [sdram_ahb_pkg::WB_LINE_SIZE -1:0] wrd_o,
  output logic [sdram_ahb_pkg::WB_LINE_BYTES-1:0] wrbe_o
);
  import sdram_ahb_pkg::*;

  logic [WB_LINE_SIZE -1:0] line_q [2];
  logic [WB_LINE_BYTES-1:0] be_q   [2];
  logic [WB_TAG_SIZE  -1:0] tag_q  [2];
  logic [1:0]               dirty_q;
  logic                     toggle_d;

  //////////////////////////////////////////////////
  // Line storage, merge per byte
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK)
    if (wb_we_i)
    begin
      tag_q[active_o] <= beat_tag_i;
      for (int b = 0; b < HDATA_BYTES; b++)
        if (beat_be_i[b])
          line_q[active_o][beat_idx_i*HDATA_SIZE + b*8 +: 8] <= HWDATA_i[b*8 +: 8];
    end

  // Active pointer, byte enables, dirty flags
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      active_o <= 1'b0;
      dirty_q  <= 2'b00;
      be_q[0]  <= '0;
      be_q[1]  <= '0;
    end
    else
    begin
      // Half becoming active starts with no lanes
      if (pingpong_toggle_i)
      begin
        active_o        <= ~active_o;
        be_q[~active_o] <= '0;
      end

      if (wb_we_i)
      begin
        be_q[active_o][beat_idx_i*HDATA_BYTES +: HDATA_BYTES] <=
          be_q[active_o][beat_idx_i*HDATA_BYTES +: HDATA_BYTES] | beat_be_i;
        dirty_q[active_o] <= 1'b1;
      end

      // Released half is clean once SDRAM takes it
      if (wr_accept_i)
        dirty_q[~active_o] <= 1'b0;
    end

  // Beat in its data phase counts as stored already
  assign dirty0_o = dirty_q[0] | (wb_we_i & ~active_o);
  assign dirty1_o = dirty_q[1] | (wb_we_i &  active_o);
  assign tag0_o   = (wb_we_i && !active_o) ? beat_tag_i : tag_q[0];
  assign tag1_o   = (wb_we_i &&  active_o) ? beat_tag_i : tag_q[1];

  //////////////////////////////////////////////////
  // Flush read-out
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
      toggle_d <= 1'b0;
    else
      toggle_d <= pingpong_toggle_i;

  // One cycle after the swap, last beat included
  always_ff @(posedge HCLK)
    if (toggle_d)
    begin
      wrd_o  <= line_q[~active_o];
      wrbe_o <= be_q[~active_o];
    end

endmodule

/* design/write_flush_ctrl.sv */
`timescale 1ns/1ps

module write_flush_ctrl (
  input  logic                                   HCLK,
  input  logic                                   HRESETn,
  input  logic                                   HREADY_i,
  input  logic                                   addr_write_i,
  input  logic                                   addr_read_i,
  input  logic [sdram_ahb_pkg::WB_TAG_SIZE -1:0] addr_tag_i,
  input  logic                                   beat_write_i,
  input  logic                                   active_i,
  input  logic [sdram_ahb_pkg::WB_TAG_SIZE -1:0] tag0_i,
  input  logic [sdram_ahb_pkg::WB_TAG_SIZE -1:0] tag1_i,
  input  logic                                   dirty0_i,
  input  logic                                   dirty1_i,
  input  logic [sdram_ahb_pkg::TIMEOUT_SIZE-1:0] wb_timeout_i,
  input  logic                                   wrrdy_i,
  input  logic                                   rd_ready_i,
  output logic                                   wb_we_o,
  output logic                                   pingpong_toggle_o,
  output logic                                   wr_accept_o,
  output logic                                   wr_pending_o,
  output logic                                   wrreq_o,
  output logic [sdram_ahb_pkg::HADDR_SIZE  -1:0] wradr_o,
  output logic                                   HREADYOUT_o
);
  import sdram_ahb_pkg::*;

  wr_state_t              wr_state, wr_nxt;
  logic                   dirty_act, dirty_oth, xfer, wr_miss, rd_hit, flush_hit;
  logic [WB_TAG_SIZE-1:0] tag_act;
  logic [TIMER_SIZE -1:0] timer_q, reload;
  logic                   expired, pend_q, toggle_d, rdy_wr;

  assign dirty_act = active_i ? dirty1_i : dirty0_i;
  assign dirty_oth = active_i ? dirty0_i : dirty1_i;
  assign tag_act   = active_i ? tag1_i   : tag0_i;

  // Beat completes when the bus is ready
  assign wb_we_o     = beat_write_i & HREADY_i;
  assign wr_accept_o = wrreq_o & wrrdy_i;

  //////////////////////////////////////////////////
  // Flush decision
  //////////////////////////////////////////////////
  assign xfer      = HREADY_i & (addr_write_i | addr_read_i);
  assign wr_miss   = addr_write_i & dirty_act & (addr_tag_i != tag_act);
  // Hit on released half already waits on wr_pending
  assign rd_hit    = addr_read_i & dirty_act & (addr_tag_i == tag_act);
  assign flush_hit = HREADY_i & (wr_miss | rd_hit);

  // Reads hold off while a flush is owed
  assign wr_pending_o = pend_q | (HREADY_i & rd_hit);

  always_comb
  begin
    wr_nxt            = wr_state;
    rdy_wr            = 1'b1;
    pingpong_toggle_o = 1'b0;
    case (wr_state)
      WR_IDLE:
        if (flush_hit || (!xfer && expired))
        begin
          if (!dirty_oth || wr_accept_o)
            pingpong_toggle_o = 1'b1;
          else if (flush_hit)
          begin
            // Other half still owed, stall the bus
            rdy_wr = 1'b0;
            wr_nxt = WR_WAIT;
          end
        end
      WR_WAIT:
      begin
        rdy_wr            = wr_accept_o;
        pingpong_toggle_o = wr_accept_o;
        if (wr_accept_o)
          wr_nxt = WR_IDLE;
      end
      default: wr_nxt = WR_IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // Idle timer
  //////////////////////////////////////////////////
  assign reload = {{(TIMER_SIZE-1){1'b0}}, 1'b1} << wb_timeout_i;

  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
      timer_q <= '0;
    else if (!dirty_act || wb_we_o || pingpong_toggle_o)
      timer_q <= reload;
    else if (|timer_q)
      timer_q <= timer_q - 1'b1;

  // Zero timeout disables expiry
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
      expired <= 1'b0;
    else if (~|wb_timeout_i || pingpong_toggle_o || wb_we_o)
      expired <= 1'b0;
    else if (dirty_act && ~|timer_q)
      expired <= 1'b1;

  //////////////////////////////////////////////////
  // Request and ready registers
  //////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      wr_state    <= WR_IDLE;
      pend_q      <= 1'b0;
      toggle_d    <= 1'b0;
      wrreq_o     <= 1'b0;
      HREADYOUT_o <= 1'b1;
    end
    else
    begin
      wr_state    <= wr_nxt;
      pend_q      <= pingpong_toggle_o | (pend_q & ~wr_accept_o);
      toggle_d    <= pingpong_toggle_o;
      // Extra cycle, flush data trails the swap
      wrreq_o     <= toggle_d | (wrreq_o & ~wrrdy_i);
      HREADYOUT_o <= rdy_wr & rd_ready_i;
    end

  // Line base of the half being released
  always_ff @(posedge HCLK)
    if (pingpong_toggle_o)
      wradr_o <= {tag_act, {WB_OFFS_BITS{1'b0}}};

endmodule

/* design/read_fifo.sv */
`timescale 1ns/1ps

module read_fifo (
  input  logic                                            HCLK,
  input  logic                                            HRESETn,
  input  logic [sdram_ahb_pkg::DQ_SIZE-1:0]               d_i,
  input  logic                                            wr_i,
  input  logic                                            rd_i,
  output logic [sdram_ahb_pkg::DQ_SIZE-1:0]               q_o,
  output logic                                            empty_o,
  output logic [$clog2(sdram_ahb_pkg::RDFIFO_DEPTH):0]    count_o
);
  import sdram_ahb_pkg::*;

  logic [DQ_SIZE-1:0]              mem [RDFIFO_DEPTH];
  logic [$clog2(RDFIFO_DEPTH)-1:0] wp, rp;

  always_ff @(posedge HCLK)
    if (wr_i)
      mem[wp] <= d_i;

  // Pointers wrap by width
  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      wp      <= '0;
      rp      <= '0;
      count_o <= '0;
    end
    else
    begin
      if (wr_i)
        wp <= wp + 1'b1;
      if (rd_i)
        rp <= rp + 1'b1;
      count_o <= count_o + $bits(count_o)'(wr_i) - $bits(count_o)'(rd_i);
    end

  // Head entry, no read latency
  assign q_o     = mem[rp];
  assign empty_o = (count_o == '0);

endmodule

/* design/read_path.sv */
`timescale 1ns/1ps

module read_path (
  input  logic                                 HCLK,
  input  logic                                 HRESETn,
  input  logic                                 HREADY_i,
  input  logic                                 addr_read_i,
  input  logic [sdram_ahb_pkg::HADDR_SIZE-1:0] addr_rdadr_i,
  input  logic                                 wr_pending_i,
  input  logic                                 rdrdy_i,
  input  logic [sdram_ahb_pkg::DQ_SIZE   -1:0] rdq_i,
  input  logic                                 rdqvalid_i,
  output logic                                 rdreq_o,
  output logic [sdram_ahb_pkg::HADDR_SIZE-1:0] rdadr_o,
  output logic [sdram_ahb_pkg::HDATA_SIZE-1:0] HRDATA_o,
  output logic                                 rd_ready_o
);
  import sdram_ahb_pkg::*;

  rd_state_t                     rd_state, rd_nxt;
  logic                          rdreq_set, pop, hi, empty;
  logic [DQ_SIZE-1:0]            q;
  logic [$clog2(RDFIFO_DEPTH):0] count;

  read_fifo u_fifo (
    .HCLK, .HRESETn,
    .d_i (rdq_i), .wr_i (rdqvalid_i), .rd_i (pop),
    .q_o (q), .empty_o (empty), .count_o (count)
  );

  // Both words present before the first pop
  assign pop = (rd_state == RD_DATA) && !empty && (hi || count >= 2);

  //////////////////////////////////////////////////
  // Read FSM
  //////////////////////////////////////////////////
  always_comb
  begin
    rd_nxt     = rd_state;
    rd_ready_o = 1'b0;
    rdreq_set  = 1'b0;
    case (rd_state)
      RD_IDLE:
        if (HREADY_i && addr_read_i)
        begin
          rdreq_set = ~wr_pending_i;
          rd_nxt    = wr_pending_i ? RD_REQ : RD_DATA;
        end
        else
          rd_ready_o = 1'b1;
      // Flush goes out first
      RD_REQ:
        if (!wr_pending_i)
        begin
          rdreq_set = 1'b1;
          rd_nxt    = RD_DATA;
        end
      RD_DATA:
        if (pop && hi)
        begin
          rd_ready_o = 1'b1;
          rd_nxt     = RD_IDLE;
        end
      default: rd_nxt = RD_IDLE;
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
    if (!HRESETn)
    begin
      rd_state <= RD_IDLE;
      rdreq_o  <= 1'b0;
      hi       <= 1'b0;
    end
    else
    begin
      rd_state <= rd_nxt;
      rdreq_o  <= rdreq_set | (rdreq_o & ~rdrdy_i);
      if (pop)
        hi <= ~hi;
    end

  // Held from the address phase until accepted
  always_ff @(posedge HCLK)
    if (rd_state == RD_IDLE && HREADY_i && addr_read_i)
      rdadr_o <= addr_rdadr_i;

  // Low half arrives first
  always_ff @(posedge HCLK)
    if (pop)
      HRDATA_o[hi*DQ_SIZE +: DQ_SIZE] <= q;

endmodule

/* design/sdram_ahb_if.sv */
`timescale 1ns/1ps

module sdram_ahb_if (
  input  logic                                    HCLK,
  input  logic                                    HRESETn,
  input  logic                                    HSEL_i,
  input  sdram_ahb_pkg::htrans_t                  HTRANS_i,
  input  sdram_ahb_pkg::hsize_t                   HSIZE_i,
  input  logic                                    HWRITE_i,
  input  logic [sdram_ahb_pkg::HADDR_SIZE   -1:0] HADDR_i,
  input  logic [sdram_ahb_pkg::HDATA_SIZE   -1:0] HWDATA_i,
  input  logic                                    HREADY_i,
  output logic [sdram_ahb_pkg::HDATA_SIZE   -1:0] HRDATA_o,
  output logic                                    HREADYOUT_o,
  input  logic [sdram_ahb_pkg::TIMEOUT_SIZE -1:0] wb_timeout_i,
  output logic                                    wrreq_o,
  input  logic                                    wrrdy_i,
  output logic [sdram_ahb_pkg::HADDR_SIZE   -1:0] wradr_o,
  output logic [sdram_ahb_pkg::WB_LINE_SIZE -1:0] wrd_o,
  output logic [sdram_ahb_pkg::WB_LINE_BYTES-1:0] wrbe_o,
  output logic                                    rdreq_o,
  input  logic                                    rdrdy_i,
  output logic [sdram_ahb_pkg::HADDR_SIZE   -1:0] rdadr_o,
  input  logic [sdram_ahb_pkg::DQ_SIZE      -1:0] rdq_i,
  input  logic                                    rdqvalid_i
);
  import sdram_ahb_pkg::*;

  // Address phase decode
  logic                   addr_write, addr_read;
  logic [WB_TAG_SIZE-1:0] addr_tag;
  logic [HADDR_SIZE -1:0] addr_rdadr;

  // Registered data phase beat
  logic                   beat_write;
  logic [HDATA_BYTES-1:0] beat_be;
  logic [WB_IDX_BITS-1:0] beat_idx;
  logic [WB_TAG_SIZE-1:0] beat_tag;

  // Write buffer state and control
  logic                   wb_we, pingpong_toggle, wr_accept, wr_pending;
  logic                   active, dirty0, dirty1;
  logic [WB_TAG_SIZE-1:0] tag0, tag1;
  logic                   rd_ready;

  ahb_addr_phase u_addr (
    .HCLK, .HRESETn, .HSEL_i, .HTRANS_i, .HSIZE_i, .HWRITE_i, .HADDR_i, .HREADY_i,
    .addr_write_o (addr_write), .addr_read_o  (addr_read),
    .addr_tag_o   (addr_tag),   .addr_rdadr_o (addr_rdadr),
    .beat_write_o (beat_write), .beat_be_o    (beat_be),
    .beat_idx_o   (beat_idx),   .beat_tag_o   (beat_tag)
  );

  write_buffer u_wbuf (
    .HCLK, .HRESETn, .HWDATA_i,
    .beat_be_i (beat_be), .beat_idx_i (beat_idx), .beat_tag_i (beat_tag),
    .wb_we_i (wb_we), .pingpong_toggle_i (pingpong_toggle), .wr_accept_i (wr_accept),
    .active_o (active), .tag0_o (tag0), .tag1_o (tag1),
    .dirty0_o (dirty0), .dirty1_o (dirty1), .wrd_o, .wrbe_o
  );

  write_flush_ctrl u_wctrl (
    .HCLK, .HRESETn, .HREADY_i,
    .addr_write_i (addr_write), .addr_read_i (addr_read), .addr_tag_i (addr_tag),
    .beat_write_i (beat_write), .active_i (active), .tag0_i (tag0), .tag1_i (tag1),
    .dirty0_i (dirty0), .dirty1_i (dirty1), .wb_timeout_i, .wrrdy_i,
    .rd_ready_i (rd_ready),
    .wb_we_o (wb_we), .pingpong_toggle_o (pingpong_toggle), .wr_accept_o (wr_accept),
    .wr_pending_o (wr_pending), .wrreq_o, .wradr_o, .HREADYOUT_o
  );

  read_path u_rpath (
    .HCLK, .HRESETn, .HREADY_i,
    .addr_read_i (addr_read), .addr_rdadr_i (addr_rdadr), .wr_pending_i (wr_pending),
    .rdrdy_i, .rdq_i, .rdqvalid_i,
    .rdreq_o, .rdadr_o, .HRDATA_o, .rd_ready_o (rd_ready)
  );

endmodule

/* testbench/sdram_mem_model.sv */
`timescale 1ns/1ps

module sdram_mem_model (
  input  logic         HCLK,
  input  logic         HRESETn,
  input  logic         wrreq_i,
  input  logic [31:0]  wradr_i,
  input  logic [127:0] wrd_i,
  input  logic [15:0]  wrbe_i,
  output logic         wrrdy_o,
  input  logic         rdreq_i,
  input  logic [31:0]  rdadr_i,
  output logic         rdrdy_o,
  output logic [15:0]  rdq_o,
  output logic         rdqvalid_o
);

  logic [7:0]  mem [0:4095];
  integer      seed;
  int          flush_count, flushes_at_read, wr_cnt, rd_cnt, rd_phase, rd_sent;
  bit          wr_busy;
  logic [31:0] last_adr, last_rdadr;
  logic [15:0] last_be;
  logic [127:0] last_data;
  logic [15:0] rd_word [2];

  initial
  begin
    seed = 30643;
    wrrdy_o = 1'b0;
    rdrdy_o = 1'b0;
    rdq_o = '0;
    rdqvalid_o = 1'b0;
    flush_count = 0;
    flushes_at_read = 0;
    wr_busy = 1'b0;
    rd_phase = 0;
    // Fill depends on all twelve address bits
    for (int i = 0; i < 4096; i++)
      mem[i] = i[7:0] ^ {i[11:8], i[11:8]} ^ 8'h5a;
  end

  //////////////////////////////////////////////////
  // Write side, random ready delay
  //////////////////////////////////////////////////
  always @(negedge HCLK)
  begin
    wrrdy_o = 1'b0;
    if (HRESETn && wrreq_i && !wr_busy)
    begin
      wr_busy = 1'b1;
      wr_cnt = $random(seed) & 3;
    end
    if (wr_busy)
    begin
      if (wr_cnt == 0)
      begin
        wrrdy_o = 1'b1;
        wr_busy = 1'b0;
        // Apply the line byte by byte
        for (int k = 0; k < 16; k++)
          if (wrbe_i[k])
            mem[(wradr_i[11:0] + k) & 12'hfff] = wrd_i[k*8 +: 8];
        last_adr = wradr_i;
        last_be = wrbe_i;
        last_data = wrd_i;
        flush_count++;
      end
      else
        wr_cnt--;
    end
  end

  //////////////////////////////////////////////////
  // Read side, two words, low half first
  //////////////////////////////////////////////////
  always @(negedge HCLK)
  begin
    rdrdy_o = 1'b0;
    rdqvalid_o = 1'b0;
    if (rd_phase == 0 && HRESETn && rdreq_i)
    begin
      rd_phase = 1;
      rd_cnt = $random(seed) & 3;
    end
    else if (rd_phase == 1)
    begin
      if (rd_cnt == 0)
      begin
        rdrdy_o = 1'b1;
        rd_word[0] = {mem[rdadr_i[11:0] + 1], mem[rdadr_i[11:0]]};
        rd_word[1] = {mem[rdadr_i[11:0] + 3], mem[rdadr_i[11:0] + 2]};
        last_rdadr = rdadr_i;
        flushes_at_read = flush_count;
        rd_sent = 0;
        rd_phase = 2;
      end
      else
        rd_cnt--;
    end
    else if (rd_phase == 2 && ($random(seed) & 1))
    begin
      // One-cycle valid pulse per word
      rdqvalid_o = 1'b1;
      rdq_o = rd_word[rd_sent];
      rd_sent++;
      if (rd_sent == 2)
        rd_phase = 0;
    end
  end

endmodule

/* testbench/sdram_ahb_chk.sv */
`timescale 1ns/1ps

module sdram_ahb_chk (
  input logic         HCLK,
  input logic         HRESETn,
  input logic         wrreq_o,
  input logic         wrrdy_i,
  input logic [31:0]  wradr_o,
  input logic [127:0] wrd_o,
  input logic [15:0]  wrbe_o,
  input logic         rdreq_o,
  input logic         rdrdy_i,
  input logic [31:0]  rdadr_o
);

  // Write request held with its payload until taken
  wr_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    wrreq_o && !wrrdy_i |=> wrreq_o && $stable(wradr_o) && $stable(wrd_o) && $stable(wrbe_o))
    else $error("write request dropped or payload changed before wrrdy_i");

  // Read request held with its address
  rd_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    rdreq_o && !rdrdy_i |=> rdreq_o && $stable(rdadr_o))
    else $error("read request dropped or address changed before rdrdy_i");

  // A flush always carries some bytes
  be_nonzero: assert property (@(posedge HCLK) disable iff (!HRESETn)
    wrreq_o |-> wrbe_o != '0)
    else $error("wrbe_o is zero during a write request");

endmodule

bind sdram_ahb_if sdram_ahb_chk u_chk (
  .HCLK (HCLK), .HRESETn (HRESETn),
  .wrreq_o (wrreq_o), .wrrdy_i (wrrdy_i), .wradr_o (wradr_o),
  .wrd_o (wrd_o), .wrbe_o (wrbe_o),
  .rdreq_o (rdreq_o), .rdrdy_i (rdrdy_i), .rdadr_o (rdadr_o)
);

/* testbench/tb_sdram_ahb_if.sv */
`timescale 1ns/1ps

module tb_sdram_ahb_if;
  import sdram_ahb_pkg::*;

  logic HCLK, HRESETn, HSEL, HWRITE, HREADYOUT, wrreq, wrrdy, rdreq, rdrdy, rdqvalid;
  htrans_t HTRANS;
  hsize_t HSIZE;
  logic [31:0] HADDR, HWDATA, HRDATA, wradr, rdadr, exp_rd;
  logic [3:0] wb_timeout;
  logic [127:0] wrd;
  logic [15:0] wrbe, rdq, exp_be;
  logic [7:0] shadow [0:4095];
  integer seed;
  int errors, test_err, tests_ok, tests_bad, c0, wait_limit;
  bit rd_dphase, ok;

  sdram_ahb_if UUT (
    .HCLK, .HRESETn, .HSEL_i (HSEL), .HTRANS_i (HTRANS), .HSIZE_i (HSIZE),
    .HWRITE_i (HWRITE), .HADDR_i (HADDR), .HWDATA_i (HWDATA), .HREADY_i (HREADYOUT),
    .HRDATA_o (HRDATA), .HREADYOUT_o (HREADYOUT), .wb_timeout_i (wb_timeout),
    .wrreq_o (wrreq), .wrrdy_i (wrrdy), .wradr_o (wradr), .wrd_o (wrd), .wrbe_o (wrbe),
    .rdreq_o (rdreq), .rdrdy_i (rdrdy), .rdadr_o (rdadr), .rdq_i (rdq), .rdqvalid_i (rdqvalid)
  );

  sdram_mem_model mem_model (
    .HCLK, .HRESETn, .wrreq_i (wrreq), .wradr_i (wradr), .wrd_i (wrd), .wrbe_i (wrbe),
    .wrrdy_o (wrrdy), .rdreq_i (rdreq), .rdadr_i (rdadr), .rdrdy_o (rdrdy),
    .rdq_o (rdq), .rdqvalid_o (rdqvalid)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  // Lanes from size and low address bits
  function automatic logic [3:0] lanes_of(hsize_t sz, logic [31:0] a);
    case (sz)
      BYTE:    return 4'b0001 << a[1:0];
      HWORD:   return 4'b0011 << a[1:0];
      default: return 4'b1111;
    endcase
  endfunction

  // Little endian word from the shadow memory
  function automatic logic [31:0] expected_word(logic [31:0] a);
    logic [11:0] w;
    w = {a[11:2], 2'b00};
    return {shadow[w + 3], shadow[w + 2], shadow[w + 1], shadow[w]};
  endfunction

  task automatic report_mismatch(string name, logic [127:0] exp, logic [127:0] got);
    $display("FAILED %s: expected %h, got %h", name, exp, got);
    errors++;
    test_err++;
  endtask

  task automatic report_error(string what);
    $display("%s", what);
    errors++;
    test_err++;
  endtask

  task automatic stop_on_timeout(string what);
    $display("Timeout: %s", what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic end_test(int n, string name);
    if (test_err == 0)
    begin
      $display("test %0d %s: ok", n, name);
      tests_ok++;
    end
    else
    begin
      $display("test %0d %s: %0d errors", n, name, test_err);
      tests_bad++;
    end
    test_err = 0;
  endtask

  //////////////////////////////////////////////////
  // AHB master, one transfer at a time
  //////////////////////////////////////////////////
  task automatic ahb_xfer(logic wr, logic [31:0] a, hsize_t sz, logic [31:0] wdata);
    int t;
    logic [3:0] ln;
    t = 0;
    while (!HREADYOUT)
    begin
      @(negedge HCLK);
      t++;
      if (t > wait_limit)
        stop_on_timeout("bus never ready for the address phase");
    end
    HSEL = 1'b1;
    HTRANS = NONSEQ;
    HADDR = a;
    HWRITE = wr;
    HSIZE = sz;
    if (!wr)
      exp_rd = expected_word(a);
    @(negedge HCLK);
    // Data phase
    HSEL = 1'b0;
    HTRANS = IDLE;
    HWDATA = wdata;
    rd_dphase = !wr;
    if (wr)
    begin
      ln = lanes_of(sz, a);
      for (int b = 0; b < 4; b++)
        if (ln[b])
          shadow[{a[11:2], 2'b00} + b] = wdata[b*8 +: 8];
    end
    t = 0;
    while (!HREADYOUT)
    begin
      @(negedge HCLK);
      t++;
      if (t > wait_limit)
        stop_on_timeout("data phase never completed");
    end
    // Word address seen by the SDRAM side
    if (!wr && mem_model.last_rdadr !== {a[31:2], 2'b00})
      report_mismatch("rdadr_o", {a[31:2], 2'b00}, mem_model.last_rdadr);
    @(negedge HCLK);
    rd_dphase = 1'b0;
  endtask

  // Read data checked where the data phase ends
  always @(posedge HCLK)
    if (rd_dphase && HREADYOUT)
      if (HRDATA !== exp_rd)
        report_mismatch("HRDATA_o", exp_rd, HRDATA);

  task automatic wait_flushes(int n, int limit, output bit done);
    int t;
    t = 0;
    while (mem_model.flush_count < n && t < limit)
    begin
      @(negedge HCLK);
      t++;
    end
    done = (mem_model.flush_count >= n);
  endtask

  task automatic idle(int n);
    repeat (n) @(negedge HCLK);
  endtask

  // Flushed bytes against the shadow memory
  task automatic check_flush(logic [31:0] adr, logic [15:0] be);
    if (mem_model.last_adr !== adr)
      report_mismatch("wradr_o", adr, mem_model.last_adr);
    if (mem_model.last_be !== be)
      report_mismatch("wrbe_o", be, mem_model.last_be);
    for (int k = 0; k < 16; k++)
      if (be[k] && mem_model.last_data[k*8 +: 8] !== shadow[adr[11:0] + k])
        report_mismatch("wrd_o byte", shadow[adr[11:0] + k], mem_model.last_data[k*8 +: 8]);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial
  begin
    logic [31:0] a;
    hsize_t sz;
    seed = 30643;
    wait_limit = 500;
    errors = 0;
    test_err = 0;
    tests_ok = 0;
    tests_bad = 0;
    rd_dphase = 1'b0;
    HRESETn = 1'b0;
    HSEL = 1'b0;
    HTRANS = IDLE;
    HSIZE = WORD;
    HWRITE = 1'b0;
    HADDR = '0;
    HWDATA = '0;
    wb_timeout = 4'd0;
    for (int i = 0; i < 4096; i++)
      shadow[i] = i[7:0] ^ {i[11:8], i[11:8]} ^ 8'h5a;
    repeat (10) @(negedge HCLK);
    HRESETn = 1'b1;

    // 1: quiet after reset
    repeat (20)
    begin
      @(negedge HCLK);
      if (HREADYOUT !== 1'b1)
        report_mismatch("HREADYOUT_o", 1, HREADYOUT);
      if (wrreq !== 1'b0 || rdreq !== 1'b0)
        report_mismatch("wrreq_o/rdreq_o", 0, {wrreq, rdreq});
    end
    end_test(1, "reset state");

    // 2: full line, then a tag miss
    c0 = mem_model.flush_count;
    for (int w = 0; w < 4; w++)
      ahb_xfer(1, 32'h100 + w*4, WORD, $random(seed));
    ahb_xfer(1, 32'h200, WORD, $random(seed));
    wait_flushes(c0 + 1, wait_limit, ok);
    if (!ok)
      report_error("No flush after the tag miss");
    check_flush(32'h100, 16'hffff);
    idle(30);
    if (mem_model.flush_count != c0 + 1)
      report_mismatch("flush count", c0 + 1, mem_model.flush_count);
    end_test(2, "line flush on miss");

    // 3: byte and halfword merge
    c0 = mem_model.flush_count;
    ahb_xfer(1, 32'h301, BYTE, $random(seed));
    ahb_xfer(1, 32'h306, HWORD, $random(seed));
    ahb_xfer(1, 32'h307, BYTE, $random(seed));
    ahb_xfer(1, 32'h30c, BYTE, $random(seed));
    ahb_xfer(1, 32'h304, BYTE, $random(seed));
    exp_be = 16'b0001_0000_1101_0010;
    ahb_xfer(1, 32'h400, WORD, $random(seed));
    wait_flushes(c0 + 2, wait_limit, ok);
    if (!ok)
      report_error("Merged line was never flushed");
    check_flush(32'h300, exp_be);
    end_test(3, "sub-word merge");

    // 4: read of an unflushed line
    c0 = mem_model.flush_count;
    ahb_xfer(1, 32'h504, WORD, $random(seed));
    ahb_xfer(0, 32'h504, WORD, 0);
    // Miss flush of the old line and the read hit flush land first
    if (mem_model.flushes_at_read < c0 + 2)
      report_error("Read reached SDRAM before the flush");
    end_test(4, "read after write");

    // 5: idle timer on and off
    wb_timeout = 4'd3;
    c0 = mem_model.flush_count;
    ahb_xfer(1, 32'h600, WORD, $random(seed));
    wait_flushes(c0 + 1, 64, ok);
    if (!ok)
      report_error("Idle timer flush missing");
    else if (mem_model.last_adr !== 32'h600)
      report_mismatch("wradr_o", 32'h600, mem_model.last_adr);
    wb_timeout = 4'd0;
    ahb_xfer(1, 32'h700, WORD, $random(seed));
    idle(10);
    c0 = mem_model.flush_count;
    idle(200);
    if (mem_model.flush_count != c0)
      report_mismatch("flush count", c0, mem_model.flush_count);
    end_test(5, "idle timer");

    // 6: random mix over four lines
    wb_timeout = 4'd2;
    repeat (120)
    begin
      a = 32'h800 + ($random(seed) & 63);
      if ($random(seed) & 1)
        ahb_xfer(0, {a[31:2], 2'b00}, WORD, 0);
      else
      begin
        case ($random(seed) & 3)
          0: sz = BYTE;
          1: sz = HWORD;
          default: sz = WORD;
        endcase
        if (sz == HWORD)
          a[0] = 1'b0;
        if (sz == WORD)
          a[1:0] = 2'b00;
        ahb_xfer(1, a, sz, $random(seed));
      end
      idle($random(seed) & 3);
    end
    end_test(6, "random traffic");

    $display("tests passed: %0d, tests failed: %0d, errors: %0d", tests_ok, tests_bad, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* sdram_ahb.f */
design/sdram_ahb_pkg.sv
design/ahb_addr_phase.sv
design/write_buffer.sv
design/write_flush_ctrl.sv
design/read_fifo.sv
design/read_path.sv
design/sdram_ahb_if.sv
testbench/sdram_mem_model.sv
testbench/sdram_ahb_chk.sv
testbench/tb_sdram_ahb_if.sv

/* Makefile */
# Verilator build and run for the sdram_ahb project

VERILATOR ?= verilator
TOP       ?= tb_sdram_ahb_if
FILELIST  ?= sdram_ahb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
